// File: source/rv_pkg.sv
package rv_pkg;

  // machine word and register index widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcodes handled by the core, everything else decodes as illegal
  typedef enum logic [6:0] {
    op_reg_reg = 7'b0110011,
    op_reg_imm = 7'b0010011,
    op_lui     = 7'b0110111,
    op_branch  = 7'b1100011,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_system  = 7'b1110011
  } opcode_e;

  // alu operations
  // alu_pass_b forwards the second operand, used for lui
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_e;

  // branch conditions, encoded the same as funct3
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_e;

  // write-back source
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_link = 2'd1
  } wb_sel_e;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    wb_sel_e               wb_sel;
    logic                  reg_write;
    logic                  is_branch;
    branch_e               branch_cond;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_ecall;
    logic                  illegal;
  } decoded_insn_t;

  // one record per executed instruction
  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic                  we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  illegal;
  } retire_t;

endpackage

// File: source/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  logic [rv_pkg::xlen-1:0] insn_i,
  output rv_pkg::decoded_insn_t   dec_o
);

  // funct7 value that selects sub and the arithmetic right shifts
  localparam logic [6:0] funct7_alt = 7'b0100000;

  rv_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic [rv_pkg::xlen-1:0] imm_u;

  assign opcode = rv_pkg::opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  // immediates, all sign-extended from bit 31
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'd0};

  always_comb begin
    dec_o = '0;
    dec_o.rd = insn_i[11:7];
    dec_o.rs1 = insn_i[19:15];
    dec_o.rs2 = insn_i[24:20];
    dec_o.imm = imm_i;
    dec_o.alu_op = rv_pkg::alu_add;
    dec_o.wb_sel = rv_pkg::wb_alu;
    dec_o.branch_cond = rv_pkg::branch_e'(funct3);

    case (opcode)
      rv_pkg::op_reg_reg: begin
        dec_o.reg_write = 1'b1;
        if (funct7 == 7'd0) begin
          case (funct3)
            3'b000: dec_o.alu_op = rv_pkg::alu_add;
            3'b001: dec_o.alu_op = rv_pkg::alu_sll;
            3'b010: dec_o.alu_op = rv_pkg::alu_slt;
            3'b011: dec_o.alu_op = rv_pkg::alu_sltu;
            3'b100: dec_o.alu_op = rv_pkg::alu_xor;
            3'b101: dec_o.alu_op = rv_pkg::alu_srl;
            3'b110: dec_o.alu_op = rv_pkg::alu_or;
            default: dec_o.alu_op = rv_pkg::alu_and;
          endcase
        end else if (funct7 == funct7_alt && funct3 == 3'b000) begin
          dec_o.alu_op = rv_pkg::alu_sub;
        end else if (funct7 == funct7_alt && funct3 == 3'b101) begin
          dec_o.alu_op = rv_pkg::alu_sra;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      rv_pkg::op_reg_imm: begin
        dec_o.reg_write = 1'b1;
        dec_o.use_imm = 1'b1;
        case (funct3)
          3'b000: dec_o.alu_op = rv_pkg::alu_add;
          3'b010: dec_o.alu_op = rv_pkg::alu_slt;
          3'b011: dec_o.alu_op = rv_pkg::alu_sltu;
          3'b100: dec_o.alu_op = rv_pkg::alu_xor;
          3'b110: dec_o.alu_op = rv_pkg::alu_or;
          3'b111: dec_o.alu_op = rv_pkg::alu_and;
          3'b001: begin
            dec_o.alu_op = rv_pkg::alu_sll;
            dec_o.illegal = (funct7 != 7'd0);
          end
          default: begin
            // funct3 101 covers srli and srai
            if (funct7 == 7'd0) begin
              dec_o.alu_op = rv_pkg::alu_srl;
            end else if (funct7 == funct7_alt) begin
              dec_o.alu_op = rv_pkg::alu_sra;
            end else begin
              dec_o.illegal = 1'b1;
            end
          end
        endcase
      end

      rv_pkg::op_lui: begin
        dec_o.reg_write = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm = imm_u;
        dec_o.alu_op = rv_pkg::alu_pass_b;
      end

      rv_pkg::op_branch: begin
        dec_o.imm = imm_b;
        // funct3 010 and 011 are reserved
        if (funct3[2:1] == 2'b01) begin
          dec_o.illegal = 1'b1;
        end else begin
          dec_o.is_branch = 1'b1;
        end
      end

      rv_pkg::op_jal: begin
        dec_o.imm = imm_j;
        dec_o.is_jal = 1'b1;
        dec_o.reg_write = 1'b1;
        dec_o.wb_sel = rv_pkg::wb_link;
      end

      rv_pkg::op_jalr: begin
        dec_o.reg_write = 1'b1;
        dec_o.wb_sel = rv_pkg::wb_link;
        if (funct3 == 3'b000) begin
          dec_o.is_jalr = 1'b1;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      rv_pkg::op_system: begin
        // only ecall, all other bits zero
        if (insn_i[31:7] == 25'd0) begin
          dec_o.is_ecall = 1'b1;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // illegal words never write back
    if (dec_o.illegal) begin
      dec_o.reg_write = 1'b0;
    end
  end

endmodule

// File: source/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we_i,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_i,
  input  logic [rv_pkg::xlen-1:0]       rd_data_i,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_i,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_i,
  output logic [rv_pkg::xlen-1:0]       rs1_data_o,
  output logic [rv_pkg::xlen-1:0]       rs2_data_o
);

  localparam int num_regs = 2 ** rv_pkg::reg_addr_w;

  logic [rv_pkg::xlen-1:0] regs [num_regs];

  // x0 reads as zero whatever the array holds
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule

// File: source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e         op_i,
  input  logic [rv_pkg::xlen-1:0] a_i,
  input  logic [rv_pkg::xlen-1:0] b_i,
  output logic [rv_pkg::xlen-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits count as shift amount
  assign shamt = b_i[4:0];

  assign lt_signed = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      rv_pkg::alu_add: result_o = a_i + b_i;
      rv_pkg::alu_sub: result_o = a_i - b_i;
      rv_pkg::alu_sll: result_o = a_i << shamt;
      rv_pkg::alu_slt: result_o = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu: result_o = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor: result_o = a_i ^ b_i;
      rv_pkg::alu_srl: result_o = a_i >> shamt;
      rv_pkg::alu_sra: result_o = $unsigned($signed(a_i) >>> shamt);
      rv_pkg::alu_or: result_o = a_i | b_i;
      rv_pkg::alu_and: result_o = a_i & b_i;
      rv_pkg::alu_pass_b: result_o = b_i;
      default: result_o = '0;
    endcase
  end

endmodule

// File: source/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::decoded_insn_t   dec_i,
  input  logic [rv_pkg::xlen-1:0] rs1_data_i,
  input  logic [rv_pkg::xlen-1:0] rs2_data_i,
  output logic [rv_pkg::xlen-1:0] pc_o,
  output logic [rv_pkg::xlen-1:0] pc_plus4_o,
  output logic                    halt_o
);

  logic [rv_pkg::xlen-1:0] pc_q;
  logic [rv_pkg::xlen-1:0] pc_next;
  logic [rv_pkg::xlen-1:0] jalr_target;
  logic                    halt_q;
  logic                    taken;

  always_comb begin
    case (dec_i.branch_cond)
      rv_pkg::br_eq: taken = rs1_data_i == rs2_data_i;
      rv_pkg::br_ne: taken = rs1_data_i != rs2_data_i;
      rv_pkg::br_lt: taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      rv_pkg::br_ge: taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      rv_pkg::br_ltu: taken = rs1_data_i < rs2_data_i;
      rv_pkg::br_geu: taken = rs1_data_i >= rs2_data_i;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4_o = pc_q + 32'd4;
  assign jalr_target = (rs1_data_i + dec_i.imm) & ~32'd1;

  always_comb begin
    if (dec_i.is_jalr) begin
      pc_next = jalr_target;
    end else if (dec_i.is_jal || (dec_i.is_branch && taken)) begin
      pc_next = pc_q + dec_i.imm;
    end else begin
      pc_next = pc_plus4_o;
    end
  end

  // ecall leaves the pc on itself and latches halt until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= reset_pc;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      if (dec_i.is_ecall) begin
        halt_q <= 1'b1;
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  assign pc_o = pc_q;
  assign halt_o = halt_q;

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] insn_i,
  output logic [rv_pkg::xlen-1:0] pc_o,
  output rv_pkg::retire_t         retire_o,
  output logic                    halt_o
);

  rv_pkg::decoded_insn_t dec;

  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] wb_data;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic                    halt;
  logic                    active;
  logic                    rf_we;

  rv_decoder u_decoder (
    .insn_i(insn_i),
    .dec_o (dec)
  );

  rv_reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .we_i      (rf_we),
    .rd_i      (dec.rd),
    .rd_data_i (wb_data),
    .rs1_i     (dec.rs1),
    .rs2_i     (dec.rs2),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op_i    (dec.alu_op),
    .a_i     (rs1_data),
    .b_i     (alu_b),
    .result_o(alu_result)
  );

  rv_pc_unit #(
    .reset_pc(reset_pc)
  ) u_pc_unit (
    .clk       (clk),
    .rst       (rst),
    .dec_i     (dec),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .pc_o      (pc_o),
    .pc_plus4_o(pc_plus4),
    .halt_o    (halt)
  );

  // link instructions write the return address
  assign wb_data = (dec.wb_sel == rv_pkg::wb_link) ? pc_plus4 : alu_result;

  // an instruction executes only out of reset and before halt
  assign active = !rst && !halt;
  assign rf_we = dec.reg_write && active;

  always_comb begin
    retire_o = '0;
    if (active) begin
      retire_o.valid = 1'b1;
      retire_o.pc = pc_o;
      retire_o.we = rf_we && (dec.rd != '0);
      retire_o.rd = dec.rd;
      retire_o.data = wb_data;
      retire_o.illegal = dec.illegal;
    end
  end

  assign halt_o = halt;

endmodule

// File: verification/rv_ref_model.svh
// architectural state of the reference model
logic [31:0] model_regs [32];
logic [31:0] model_pc;
logic        model_halted;

function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opcode);
  return {imm, rs1, f3, rd, opcode};
endfunction

function automatic logic [31:0] b_type_word(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] j_type_word(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// runs the instruction at model_pc and returns the retire record the core should report
function automatic rv_pkg::retire_t execute_insn();
  rv_pkg::retire_t res;
  logic [31:0] insn;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] sra_val;
  logic [31:0] next_pc;
  logic [31:0] wdata;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic        imm_form;
  logic        write;
  logic        bad;
  logic        taken;
  logic        halting;

  insn = fetch_word(model_pc);
  f7 = insn[31:25];
  f3 = insn[14:12];
  rd = insn[11:7];
  a = model_regs[insn[19:15]];
  b = model_regs[insn[24:20]];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  next_pc = model_pc + 32'd4;
  wdata = '0;
  write = 1'b0;
  bad = 1'b0;
  taken = 1'b0;
  halting = 1'b0;
  case (insn[6:0])
    7'b0110011, 7'b0010011: begin
      imm_form = insn[6:0] == 7'b0010011;
      if (imm_form) begin
        b = imm_i;
        bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      end else begin
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      sra_val = $signed(a) >>> b[4:0];
      write = 1'b1;
      case (f3)
        3'd0: wdata = (!imm_form && f7 == 7'h20) ? a - b : a + b;
        3'd1: wdata = a << b[4:0];
        3'd2: wdata = {31'd0, $signed(a) < $signed(b)};
        3'd3: wdata = {31'd0, a < b};
        3'd4: wdata = a ^ b;
        3'd5: wdata = (f7 == 7'h20) ? sra_val : a >> b[4:0];
        3'd6: wdata = a | b;
        default: wdata = a & b;
      endcase
    end
    7'b0110111: begin
      write = 1'b1;
      wdata = {insn[31:12], 12'd0};
    end
    7'b1100011: begin
      case (f3)
        3'd0: taken = a == b;
        3'd1: taken = a != b;
        3'd4: taken = $signed(a) < $signed(b);
        3'd5: taken = $signed(a) >= $signed(b);
        3'd6: taken = a < b;
        3'd7: taken = a >= b;
        default: bad = 1'b1;
      endcase
      if (taken) begin
        next_pc = model_pc + imm_b;
      end
    end
    7'b1101111: begin
      write = 1'b1;
      wdata = model_pc + 32'd4;
      next_pc = model_pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end
    7'b1100111: begin
      bad = f3 != 3'd0;
      write = 1'b1;
      wdata = model_pc + 32'd4;
      if (!bad) begin
        next_pc = (a + imm_i) & ~32'd1;
      end
    end
    7'b1110011: begin
      halting = insn[31:7] == 25'd0;
      bad = !halting;
    end
    default: bad = 1'b1;
  endcase

  res = '0;
  res.valid = 1'b1;
  res.pc = model_pc;
  res.we = write && !bad && rd != 5'd0;
  res.rd = rd;
  res.data = wdata;
  res.illegal = bad;
  if (res.we) begin
    model_regs[rd] = wdata;
  end
  // ecall leaves the pc where it is
  if (halting) begin
    model_halted = 1'b1;
  end else begin
    model_pc = next_pc;
  end
  return res;
endfunction

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam logic [31:0] reset_pc = 32'h0000_0100;
  localparam int prog_len = 96;
  localparam int halt_hold = 5;
  // every jump goes forward, so a run takes at most prog_len instructions
  localparam int timeout_cycles = 2 * prog_len + 20;
  localparam logic [31:0] seed = 32'h148f_287a;
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  logic            clk = 1'b0;
  logic            rst;
  logic [31:0]     insn;
  logic [31:0]     pc;
  rv_pkg::retire_t retire;
  logic            halt;

  logic [31:0] prog [prog_len];
  logic        is_target [prog_len];
  logic [31:0] lcg_state;
  int          cycle_count = 0;

  rv_core #(
    .reset_pc(reset_pc)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .insn_i  (insn),
    .pc_o    (pc),
    .retire_o(retire),
    .halt_o  (halt)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  // addresses outside the program read as ecall
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - reset_pc;
    if (offset[1:0] != 2'b00 || offset >= 32'(prog_len * 4)) begin
      return ecall_word;
    end
    return prog[int'(offset[31:2])];
  endfunction

  `include "rv_ref_model.svh"

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
    fail_run();
  endtask

  task automatic check_pc(input logic [rv_pkg::xlen-1:0] actual,
                          input logic [rv_pkg::xlen-1:0] expected);
    if (actual !== expected) begin
      report_mismatch("pc_o", expected, actual);
    end
  endtask

  task automatic check_halt(input logic actual, input logic expected);
    if (actual !== expected) begin
      report_mismatch("halt_o", 32'(expected), 32'(actual));
    end
  endtask

  // rd and data only mean something when the instruction writes a register
  task automatic check_retire(input rv_pkg::retire_t actual, input rv_pkg::retire_t expected);
    if (actual.valid !== expected.valid) begin
      report_mismatch("retire_o.valid", 32'(expected.valid), 32'(actual.valid));
    end else if (expected.valid) begin
      if (actual.pc !== expected.pc) begin
        report_mismatch("retire_o.pc", expected.pc, actual.pc);
      end
      if (actual.illegal !== expected.illegal) begin
        report_mismatch("retire_o.illegal", 32'(expected.illegal), 32'(actual.illegal));
      end
      if (actual.we !== expected.we) begin
        report_mismatch("retire_o.we", 32'(expected.we), 32'(actual.we));
      end
      if (expected.we && actual.rd !== expected.rd) begin
        report_mismatch("retire_o.rd", 32'(expected.rd), 32'(actual.rd));
      end
      if (expected.we && actual.data !== expected.data) begin
        report_mismatch("retire_o.data", expected.data, actual.data);
      end
    end
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] r2;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          i;
    int          target;
    int          last;

    last = prog_len - 1;
    for (int n = 0; n < prog_len; n++) begin
      is_target[n] = 1'b0;
    end
    // x1 to x7 start with random upper bits for negative and large operands
    for (i = 0; i < 7; i++) begin
      r = next_rand();
      prog[i] = u_type_word(r[19:0], 5'(i + 1));
    end
    while (i < last) begin
      r = next_rand();
      r2 = next_rand();
      rd = {2'b00, r[2:0]};
      rs1 = {2'b00, r[5:3]};
      rs2 = {2'b00, r[8:6]};
      f3 = r[11:9];
      // jumps skip at least one word so taken and not-taken branches differ
      target = i + 2 + int'(r[13:12]);
      if (target > last) begin
        target = last;
      end
      case (r[31:28])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd15: begin
          f7 = (r[14] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
          prog[i] = r_type_word(f7, rs2, rs1, f3, rd);
        end
        4'd9: prog[i] = u_type_word(r2[19:0], rd);
        4'd10, 4'd11: begin
          // reserved funct3 010 and 011 become bltu and bgeu
          if (f3[2:1] == 2'b01) begin
            f3[2] = 1'b1;
          end
          prog[i] = b_type_word(13'((target - i) * 4), rs2, rs1, f3);
          is_target[target] = 1'b1;
        end
        4'd12: begin
          prog[i] = j_type_word(21'((target - i) * 4), rd);
          is_target[target] = 1'b1;
        end
        4'd13: begin
          // jal x8 to the next word followed by jalr through x8
          // no branch may land on the jalr
          if (i + 2 <= last && !is_target[i + 1]) begin
            target = i + 2 + int'(r[13:12]);
            if (target > last) begin
              target = last;
            end
            prog[i] = j_type_word(21'd4, 5'd8);
            imm = 12'((target - i - 1) * 4) | {11'd0, r[15]};
            prog[i + 1] = i_type_word(imm, 5'd8, 3'd0, rd, 7'b1100111);
            is_target[i + 1] = 1'b1;
            is_target[target] = 1'b1;
            i++;
          end else begin
            prog[i] = i_type_word(r2[11:0], rs1, 3'd0, rd, 7'b0010011);
          end
        end
        // load opcode which this core does not implement
        4'd14: prog[i] = {r2[31:7], 7'b0000011};
        default: begin
          imm = r2[11:0];
          if (f3 == 3'd1) begin
            imm = {7'h00, r2[4:0]};
          end else if (f3 == 3'd5) begin
            imm = {r[14] ? 7'h20 : 7'h00, r2[4:0]};
          end
          prog[i] = i_type_word(imm, rs1, f3, rd, 7'b0010011);
        end
      endcase
      i++;
    end
    prog[last] = ecall_word;
  endtask

  // once halted the core sees a jump that its frozen pc must ignore
  initial begin
    insn = '0;
    forever begin
      @(posedge clk);
      #1;
      insn = halt ? j_type_word(21'd16, 5'd1) : fetch_word(pc);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: the core did not halt within %0d cycles", timeout_cycles);
      fail_run();
    end
  end

  initial begin
    rv_pkg::retire_t expected;
    int hold;

    rst = 1'b1;
    lcg_state = seed;
    build_program();
    model_pc = reset_pc;
    model_halted = 1'b0;
    for (int n = 0; n < 32; n++) begin
      model_regs[n] = '0;
    end

    // nothing retires and no halt while reset is held
    @(posedge clk);
    @(negedge clk);
    check_halt(halt, 1'b0);
    check_retire(retire, '0);
    @(posedge clk);
    #1;
    rst = 1'b0;

    hold = 0;
    while (hold < halt_hold) begin
      @(negedge clk);
      check_pc(pc, model_pc);
      check_halt(halt, model_halted);
      if (model_halted) begin
        expected = '0;
        hold++;
      end else begin
        expected = execute_insn();
      end
      check_retire(retire, expected);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+verification
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_reg_file.sv
source/rv_alu.sv
source/rv_pc_unit.sv
source/rv_core.sv
verification/rv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim || true)
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
